// File: Bender.yml
package:
  name: ex_stage

sources:
  - source/ex_pkg.sv
  - source/ex_mult.sv
  - source/ex_alu.sv
  - source/ex_issue.sv
  - source/ex_top.sv
  - target: simulation
    files:
      - sim/ex_top_chk.sv
      - sim/ex_tb.sv

// File: list.f
source/ex_pkg.sv
source/ex_mult.sv
source/ex_alu.sv
source/ex_issue.sv
source/ex_top.sv
sim/ex_top_chk.sv
sim/ex_tb.sv

// File: sim/ex_tb.sv
//////////////////////////////////////////////////////////////////////
// execute stage testbench
// directed ALU and multiply tests against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_tb;

  localparam int unsigned DONE_TIMEOUT = 40;
  localparam int unsigned ALU_LATENCY  = 1;
  localparam int unsigned MUL_LATENCY  = 10;
  localparam int unsigned RAND_ALU     = 20;
  localparam int unsigned RAND_MUL     = 200;

  logic             clk;
  logic             rst_n;
  logic             valid_i;
  ex_pkg::ex_req_t  req_i;
  logic             busy_o;
  logic             done_o;
  ex_pkg::ex_word_t result_o;

  int unsigned      mismatches;
  int unsigned      timeouts;
  int unsigned      seed_val;
  ex_pkg::ex_word_t corners [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                    32'h8000_0000, 32'h7fff_ffff};

  ex_top u_ex_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .result_o (result_o)
  );

  always #2 clk = ~clk;

  // reference results straight from the operator definitions
  function automatic ex_pkg::ex_word_t model_result(input ex_pkg::ex_op_e op,
                                                    input ex_pkg::ex_word_t a,
                                                    input ex_pkg::ex_word_t b);
    ex_pkg::ex_word_t r;
    case (op)
      ex_pkg::ADD:  r = a + b;
      ex_pkg::SUB:  r = a - b;
      ex_pkg::AND:  r = a & b;
      ex_pkg::OR:   r = a | b;
      ex_pkg::XOR:  r = a ^ b;
      ex_pkg::SLL:  r = a << b[4:0];
      ex_pkg::SRL:  r = a >> b[4:0];
      ex_pkg::SRA:  r = $signed(a) >>> b[4:0];
      ex_pkg::SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ex_pkg::SLTU: r = (a < b) ? 32'd1 : 32'd0;
      ex_pkg::MUL:  r = a * b;
      default:      r = '0;
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // entered 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_req(input ex_pkg::ex_op_e op, input ex_pkg::ex_word_t a,
                          input ex_pkg::ex_word_t b);
    valid_i = 1'b1;
    req_i   = '{op: op, operand_a: a, operand_b: b};
    @(posedge clk);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic wait_done(output int unsigned cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      seen = done_o;
    end
    if (!seen) begin
      timeouts++;
      $display("done_o never rose within %0d cycles", DONE_TIMEOUT);
    end
  endtask

  task automatic run_op(input ex_pkg::ex_op_e op, input ex_pkg::ex_word_t a,
                        input ex_pkg::ex_word_t b);
    int unsigned      cycles;
    ex_pkg::ex_word_t expected;
    expected = model_result(op, a, b);
    send_req(op, a, b);
    wait_done(cycles);
    check_value($sformatf("result_o (%s)", op.name()), result_o, expected);
    check_value("done_o latency", cycles, (op == ex_pkg::MUL) ? MUL_LATENCY : ALU_LATENCY);
  endtask

  task automatic test_reset();
    check_value("busy_o", busy_o, 32'd0);
    check_value("done_o", done_o, 32'd0);
    check_value("result_o", result_o, 32'd0);
  endtask

  task automatic test_alu();
    ex_pkg::ex_op_e op;
    for (int o = ex_pkg::ADD; o <= ex_pkg::SLTU; o++) begin
      op = ex_pkg::ex_op_e'(o);
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          run_op(op, corners[i], corners[j]);
        end
      end
      for (int n = 0; n < RAND_ALU; n++) begin
        run_op(op, $urandom(), $urandom());
      end
    end
  endtask

  task automatic test_mul();
    run_op(ex_pkg::MUL, 32'h0000_0000, 32'h1234_5678);
    run_op(ex_pkg::MUL, 32'h0000_0001, 32'hdead_beef);
    run_op(ex_pkg::MUL, 32'hffff_ffff, 32'hffff_ffff);
    run_op(ex_pkg::MUL, 32'hffff_fffd, 32'h0000_0005);
    run_op(ex_pkg::MUL, 32'h0000_0007, 32'hffff_ff00);
    run_op(ex_pkg::MUL, 32'h8000_0000, 32'h8000_0000);
    run_op(ex_pkg::MUL, 32'h7fff_ffff, 32'h8000_0000);
    for (int n = 0; n < RAND_MUL; n++) begin
      run_op(ex_pkg::MUL, $urandom(), $urandom());
    end
  endtask

  // strobe an ADD in the middle of a multiply
  task automatic test_ignored();
    int unsigned cycles;
    send_req(ex_pkg::MUL, 32'h0013_57bd, 32'hfedc_ba98);
    repeat (3) @(posedge clk);
    #1;
    check_value("busy_o", busy_o, 32'd1);
    send_req(ex_pkg::ADD, 32'h1111_1111, 32'h2222_2222);
    wait_done(cycles);
    check_value("result_o (ignored)", result_o, 32'h0013_57bd * 32'hfedc_ba98);
    check_value("done_o latency", 4 + cycles, MUL_LATENCY);
    // no second completion may follow
    for (int n = 0; n < 4; n++) begin
      @(posedge clk);
      #1;
      check_value("done_o", done_o, 32'd0);
      check_value("busy_o", busy_o, 32'd0);
    end
  endtask

  task automatic test_back_to_back();
    run_op(ex_pkg::MUL, 32'hcafe_f00d, 32'h0bad_cafe);
    run_op(ex_pkg::MUL, 32'hffff_fff9, 32'h0000_1234);
    run_op(ex_pkg::ADD, 32'h7fff_ffff, 32'h0000_0001);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    seed_val   = $urandom(32'h0562_c78d);
    clk        = 1'b0;
    rst_n      = 1'b0;
    valid_i    = 1'b0;
    req_i      = '0;
    mismatches = 0;
    timeouts   = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_alu();
    test_mul();
    test_ignored();
    test_back_to_back();
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, u_ex_top.u_chk.fail_count);
    if (mismatches == 0 && timeouts == 0 && u_ex_top.u_chk.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/ex_top_chk.sv
//////////////////////////////////////////////////////////////////////
// execute stage control assertions, bound into the top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_top_chk (
  input logic           clk,
  input logic           rst_n,
  input logic           valid_i,
  input logic           busy_i,
  input logic           done_i,
  input logic           mult_en_i,
  input logic           mult_ready_i,
  input ex_pkg::ex_op_e op_i
);

  int unsigned fail_count = 0;

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done_o held for more than one cycle");
    end

  done_idle: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> !busy_i)
    else begin
      fail_count++;
      $error("done_o high while busy_o is high");
    end

  ready_enabled: assert property (@(posedge clk) disable iff (!rst_n)
    mult_ready_i |-> mult_en_i)
    else begin
      fail_count++;
      $error("multiplier ready while not enabled");
    end

  // accepted multiply keeps the stage busy for every step
  mul_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && !busy_i && op_i == ex_pkg::MUL)
      |=> busy_i [*ex_pkg::MULT_STEPS] ##1 !busy_i)
    else begin
      fail_count++;
      $error("multiply busy period has the wrong length");
    end

endmodule

bind ex_top ex_top_chk u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .valid_i      (valid_i),
  .busy_i       (busy_o),
  .done_i       (done_o),
  .mult_en_i    (mult_en),
  .mult_ready_i (mult_ready),
  .op_i         (req_i.op)
);

`default_nettype wire

// File: source/ex_alu.sv
//////////////////////////////////////////////////////////////////////
// execute stage ALU
// one adder shared by arithmetic, compares and multiply steps
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_pkg::ex_req_t      req_i,
  input  ex_pkg::ex_mult_add_t mult_add_i,
  output ex_pkg::ex_word_t     adder_sum_o,
  output ex_pkg::ex_word_t     result_o
);

  ex_pkg::ex_word_t add_a;
  ex_pkg::ex_word_t add_b;
  ex_pkg::ex_word_t sum;
  logic             add_cin;
  logic             add_cout;
  logic [4:0]       shamt;
  logic             lt_signed;
  logic             lt_unsigned;

  //////////////////////////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////////////////////////

  always_comb begin : adder_operands
    add_a   = req_i.operand_a;
    add_b   = req_i.operand_b;
    add_cin = 1'b0;
    case (req_i.op)
      // a - b as a + ~b + 1
      ex_pkg::SUB, ex_pkg::SLT, ex_pkg::SLTU: begin
        add_b   = ~req_i.operand_b;
        add_cin = 1'b1;
      end
      // multiplier owns the adder
      ex_pkg::MUL: begin
        add_a = mult_add_i.pp;
        add_b = mult_add_i.acc;
      end
      default: begin
        add_cin = 1'b0;
      end
    endcase
  end

  assign {add_cout, sum} = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};

  assign adder_sum_o = sum;

  // no borrow out means a >= b
  assign lt_unsigned = ~add_cout;

  // differing signs decide directly, else sign of the difference
  assign lt_signed = (req_i.operand_a[31] == req_i.operand_b[31]) ? sum[31]
                                                                  : req_i.operand_a[31];

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  assign shamt = req_i.operand_b[4:0];

  always_comb begin : result_mux
    case (req_i.op)
      ex_pkg::ADD, ex_pkg::SUB, ex_pkg::MUL: begin
        result_o = sum;
      end
      ex_pkg::AND: begin
        result_o = req_i.operand_a & req_i.operand_b;
      end
      ex_pkg::OR: begin
        result_o = req_i.operand_a | req_i.operand_b;
      end
      ex_pkg::XOR: begin
        result_o = req_i.operand_a ^ req_i.operand_b;
      end
      ex_pkg::SLL: begin
        result_o = req_i.operand_a << shamt;
      end
      ex_pkg::SRL: begin
        result_o = req_i.operand_a >> shamt;
      end
      ex_pkg::SRA: begin
        result_o = $signed(req_i.operand_a) >>> shamt;
      end
      ex_pkg::SLT: begin
        result_o = {31'd0, lt_signed};
      end
      ex_pkg::SLTU: begin
        result_o = {31'd0, lt_unsigned};
      end
      default: begin
        result_o = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/ex_issue.sv
//////////////////////////////////////////////////////////////////////
// single-entry issue and run control
// captures one request, sequences ALU or multiply, pulses done
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_issue (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  ex_pkg::ex_req_t  req_i,
  input  ex_pkg::ex_word_t alu_result_i,
  input  logic             mult_ready_i,
  output ex_pkg::ex_req_t  req_o,
  output logic             mult_en_o,
  output logic             busy_o,
  output logic             done_o,
  output ex_pkg::ex_word_t result_o
);

  typedef enum logic [1:0] {
    IDLE,
    ALU,
    MULT
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic             accept;
  logic             finish;
  logic             done_q;
  ex_pkg::ex_req_t  req_q;
  ex_pkg::ex_word_t result_q;

  // requests while busy are dropped
  assign accept = valid_i && (state_q == IDLE);
  assign finish = (state_q == ALU) || ((state_q == MULT) && mult_ready_i);

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (valid_i) begin
          state_d = (req_i.op == ex_pkg::MUL) ? MULT : ALU;
        end
      end
      ALU: begin
        state_d = IDLE;
      end
      MULT: begin
        if (mult_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin : ctrl_reg
    if (!rst_n) begin
      state_q  <= IDLE;
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;
      if (finish) begin
        result_q <= alu_result_i;
      end
    end
  end

  // held operands for the whole run
  always_ff @(posedge clk) begin : req_reg
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign req_o     = req_q;
  assign mult_en_o = (state_q == MULT);
  assign busy_o    = (state_q != IDLE);
  assign done_o    = done_q;
  assign result_o  = result_q;

endmodule

`default_nettype wire

// File: source/ex_mult.sv
//////////////////////////////////////////////////////////////////////
// iterative multiplier, low 32 bits of a 32x32 product
// one 8x8 partial product per step, summed in the ALU adder
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mult_en_i,
  input  ex_pkg::ex_req_t      req_i,
  input  ex_pkg::ex_word_t     acc_i,
  output ex_pkg::ex_mult_add_t mult_add_o,
  output logic                 ready_o
);

  localparam int unsigned STEP_W = $clog2(ex_pkg::MULT_STEPS);

  typedef enum logic [STEP_W-1:0] {
    STEP0,
    STEP1,
    STEP2,
    STEP3,
    STEP4,
    STEP5,
    STEP6,
    STEP7,
    STEP8,
    STEP9
  } step_e;

  // byte pair and top-byte sign handling of one step
  typedef struct packed {
    logic [1:0] sel_a;
    logic [1:0] sel_b;
    logic       sgn_a;
    logic       sgn_b;
  } step_ctrl_t;

  step_e      step_q;
  step_e      step_d;
  step_ctrl_t ctrl;

  ex_pkg::ex_byte_t byte_a;
  ex_pkg::ex_byte_t byte_b;
  logic             sign_a;
  logic             sign_b;
  logic [1:0]       shift;

  logic signed [2*ex_pkg::SHIFT_W+1:0] pp_raw;

  ex_pkg::ex_word_t pp_ext;
  ex_pkg::ex_word_t pp_shifted;
  ex_pkg::ex_word_t acc_q;
  ex_pkg::ex_word_t acc_op;

  //////////////////////////////////////////////////////////////////////
  // step sequence
  //////////////////////////////////////////////////////////////////////

  // products shifted to 32 bits or beyond never appear
  always_comb begin : step_table
    case (step_q)
      STEP0: begin
        ctrl   = '{sel_a: 2'd0, sel_b: 2'd0, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP1;
      end
      STEP1: begin
        ctrl   = '{sel_a: 2'd0, sel_b: 2'd1, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP2;
      end
      STEP2: begin
        ctrl   = '{sel_a: 2'd0, sel_b: 2'd2, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP3;
      end
      STEP3: begin
        ctrl   = '{sel_a: 2'd0, sel_b: 2'd3, sgn_a: 1'b0, sgn_b: 1'b1};
        step_d = STEP4;
      end
      STEP4: begin
        ctrl   = '{sel_a: 2'd1, sel_b: 2'd0, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP5;
      end
      STEP5: begin
        ctrl   = '{sel_a: 2'd1, sel_b: 2'd1, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP6;
      end
      STEP6: begin
        ctrl   = '{sel_a: 2'd1, sel_b: 2'd2, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP7;
      end
      STEP7: begin
        ctrl   = '{sel_a: 2'd2, sel_b: 2'd0, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP8;
      end
      STEP8: begin
        ctrl   = '{sel_a: 2'd2, sel_b: 2'd1, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP9;
      end
      STEP9: begin
        ctrl   = '{sel_a: 2'd3, sel_b: 2'd0, sgn_a: 1'b1, sgn_b: 1'b0};
        step_d = STEP0;
      end
      default: begin
        ctrl   = '{sel_a: 2'd0, sel_b: 2'd0, sgn_a: 1'b0, sgn_b: 1'b0};
        step_d = STEP0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // partial product
  //////////////////////////////////////////////////////////////////////

  assign byte_a = req_i.operand_a[ctrl.sel_a * ex_pkg::SHIFT_W +: ex_pkg::SHIFT_W];
  assign byte_b = req_i.operand_b[ctrl.sel_b * ex_pkg::SHIFT_W +: ex_pkg::SHIFT_W];

  // sign only meaningful for the top bytes
  assign sign_a = ctrl.sgn_a & req_i.operand_a[31];
  assign sign_b = ctrl.sgn_b & req_i.operand_b[31];

  assign pp_raw = $signed({sign_a, byte_a}) * $signed({sign_b, byte_b});

  // sign extended to a full word
  assign pp_ext = ex_pkg::ex_word_t'(pp_raw);

  // byte weight of the pair
  assign shift      = ctrl.sel_a + ctrl.sel_b;
  assign pp_shifted = pp_ext << (shift * ex_pkg::SHIFT_W);

  // first step starts a fresh sum
  assign acc_op = (step_q == STEP0) ? '0 : acc_q;

  assign mult_add_o = '{pp: pp_shifted, acc: acc_op};
  assign ready_o    = (step_q == STEP9);

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin : step_reg
    if (!rst_n) begin
      step_q <= STEP0;
    end else if (mult_en_i) begin
      step_q <= step_d;
    end
  end

  // running sum from the shared adder
  always_ff @(posedge clk) begin : acc_reg
    if (mult_en_i) begin
      acc_q <= acc_i;
    end
  end

endmodule

`default_nettype wire

// File: source/ex_pkg.sv
//////////////////////////////////////////////////////////////////////
// execute stage shared definitions
// operator encoding, data words and the bundles between the blocks
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ex_pkg;

  // number of 8x8 partial-product steps in one multiply
  localparam int unsigned MULT_STEPS = 10;
  // distance between neighbouring operand bytes
  localparam int unsigned SHIFT_W = 8;

  typedef logic [31:0]        ex_word_t;
  typedef logic [SHIFT_W-1:0] ex_byte_t;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    MUL  = 4'd10
  } ex_op_e;

  // one operation as issued
  typedef struct packed {
    ex_op_e   op;
    ex_word_t operand_a;
    ex_word_t operand_b;
  } ex_req_t;

  // multiplier operands for the shared adder
  typedef struct packed {
    ex_word_t pp;
    ex_word_t acc;
  } ex_mult_add_t;

endpackage

`default_nettype wire

// File: source/ex_top.sv
//////////////////////////////////////////////////////////////////////
// execute stage top level
// issue control, shared-adder ALU and iterative multiplier
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid_i,
  input  ex_pkg::ex_req_t  req_i,
  output logic             busy_o,
  output logic             done_o,
  output ex_pkg::ex_word_t result_o
);

  ex_pkg::ex_req_t      req;
  ex_pkg::ex_mult_add_t mult_add;
  ex_pkg::ex_word_t     adder_sum;
  ex_pkg::ex_word_t     alu_result;
  logic                 mult_en;
  logic                 mult_ready;

  ex_issue u_issue (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .req_i        (req_i),
    .alu_result_i (alu_result),
    .mult_ready_i (mult_ready),
    .req_o        (req),
    .mult_en_o    (mult_en),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .result_o     (result_o)
  );

  ex_alu u_alu (
    .req_i       (req),
    .mult_add_i  (mult_add),
    .adder_sum_o (adder_sum),
    .result_o    (alu_result)
  );

  // adder sum feeds back as the next accumulator value
  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .mult_en_i  (mult_en),
    .req_i      (req),
    .acc_i      (adder_sum),
    .mult_add_o (mult_add),
    .ready_o    (mult_ready)
  );

endmodule

`default_nettype wire
